// ==== cpu_int_pkg.sv ====
`default_nettype none

package cpu_int_pkg;

    localparam int instr_w = 32;             // Instruction word width
    localparam int N_IRQ   = 8;              // Request lines into the controller
    localparam int ID_W    = $clog2(N_IRQ);  // Source id width

    // Opcodes sit in bits 31:27
    localparam logic [4:0] OP_JUMP = 5'b10100;
    localparam logic [4:0] OP_RETI = 5'b11111;
    localparam logic [4:0] OP_MOVI = 5'b00101;

    localparam logic [instr_w-1:0] INSTR_NOOP  = 32'h7800_0000;
    localparam logic [31:0]        RESET_PC    = 32'h0600_2000; // Start of instruction memory
    localparam logic [31:0]        VECTOR_BASE = 32'h0600_0000; // Source n at base + 16*n
    localparam logic [3:0]         ID_REG      = 4'd13;         // Receives the source id
    localparam logic [2:0]         FLUSH_DEPTH = 3'd6;          // No-op cycles per flush

    typedef enum logic [2:0] {
        NORMAL,
        FLUSH_INT,
        SAVE_REGS,
        ACK_INT,
        INJECT,
        FLUSH_RET,
        RESTORE_REGS
    } int_state_e;

    // Same word seen as a jump or as an immediate load
    typedef union packed {
        struct packed {
            logic [4:0]  op;
            logic [26:0] target;   // Absolute byte address
        } jmp;
        struct packed {
            logic [4:0]  op;
            logic [3:0]  rd;
            logic [22:0] value;
        } imm;
    } instr_u;

endpackage

`default_nettype wire

// ==== cpu_int_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_int_top (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [cpu_int_pkg::N_IRQ-1:0]   irq,
    input  logic [cpu_int_pkg::instr_w-1:0] mem_instr,
    input  logic [31:0]                     cur_lr,
    input  logic [1:0]                      cur_fl,
    output logic [31:0]                     fetch_pc,
    output logic [cpu_int_pkg::instr_w-1:0] issued_instr,
    output logic [cpu_int_pkg::N_IRQ-1:0]   irq_ack,
    output logic                            restore_valid,
    output logic [31:0]                     restore_lr,
    output logic [1:0]                      restore_fl
);
    import cpu_int_pkg::*;

    logic               int_req;        // Controller to FSM
    logic               int_ack;        // FSM to controller
    logic               inj_last;
    logic               use_int_instr;
    logic               use_noop;
    logic [instr_w-1:0] inj_instr;

    ctx_if ctx ();

    assign ctx.cur_pc = fetch_pc;        // PC to save is the frozen fetch PC
    assign ctx.cur_lr = cur_lr;
    assign ctx.cur_fl = cur_fl;

    assign restore_valid = ctx.restore;
    assign restore_lr    = ctx.saved_lr;
    assign restore_fl    = ctx.saved_fl;

    int_controller u_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .irq       (irq),
        .int_ack   (int_ack),
        .int_req   (int_req),
        .irq_ack   (irq_ack),
        .inj_instr (inj_instr),
        .inj_last  (inj_last)
    );

    int_fsm u_fsm (
        .clk           (clk),
        .rst_n         (rst_n),
        .int_req       (int_req),
        .issued_instr  (issued_instr),
        .inj_last      (inj_last),
        .int_ack       (int_ack),
        .use_int_instr (use_int_instr),
        .use_noop      (use_noop),
        .ctx           (ctx.fsm)
    );

    ctx_store u_store (
        .clk   (clk),
        .rst_n (rst_n),
        .ctx   (ctx.store)
    );

    fetch_select u_fetch (
        .clk           (clk),
        .rst_n         (rst_n),
        .mem_instr     (mem_instr),
        .inj_instr     (inj_instr),
        .use_noop      (use_noop),
        .use_int_instr (use_int_instr),
        .restore       (ctx.restore),
        .saved_pc      (ctx.saved_pc),
        .fetch_pc      (fetch_pc),
        .issued_instr  (issued_instr)
    );

endmodule

`default_nettype wire

// ==== ctx_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface ctx_if;

    logic        save;       // Capture strobe from the FSM
    logic        restore;    // Restore strobe also seen by fetch

    logic [31:0] cur_pc;     // Live fetch PC
    logic [31:0] cur_lr;     // Live link register
    logic [1:0]  cur_fl;     // Live flags

    logic [31:0] saved_pc;
    logic [31:0] saved_lr;
    logic [1:0]  saved_fl;

    modport fsm (output save, output restore);

    modport store (
        input  save, cur_pc, cur_lr, cur_fl,
        output saved_pc, saved_lr, saved_fl
    );

endinterface

`default_nettype wire

// ==== ctx_store.sv ====
`timescale 1ns/1ps
`default_nettype none

module ctx_store (
    input logic clk,
    input logic rst_n,
    ctx_if.store ctx
);
    import cpu_int_pkg::*;

    // Context taken once per entry and held through the handler
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctx.saved_pc <= RESET_PC;
            ctx.saved_lr <= RESET_PC;    // LR starts at program base too
            ctx.saved_fl <= 2'b00;       // No flags set
        end else if (ctx.save) begin
            ctx.saved_pc <= ctx.cur_pc;
            ctx.saved_lr <= ctx.cur_lr;
            ctx.saved_fl <= ctx.cur_fl;
        end
    end

endmodule

`default_nettype wire

// ==== fetch_select.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_select (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [cpu_int_pkg::instr_w-1:0] mem_instr,
    input  logic [cpu_int_pkg::instr_w-1:0] inj_instr,
    input  logic                            use_noop,
    input  logic                            use_int_instr,
    input  logic                            restore,
    input  logic [31:0]                     saved_pc,
    output logic [31:0]                     fetch_pc,
    output logic [cpu_int_pkg::instr_w-1:0] issued_instr
);
    import cpu_int_pkg::*;

    instr_u      issued_u;
    logic [31:0] pc_nxt;

    // Issue slot mux
    always_comb begin
        if (use_noop) begin
            issued_instr = INSTR_NOOP;
        end else if (use_int_instr) begin
            issued_instr = inj_instr;
        end else begin
            issued_instr = mem_instr;
        end
    end

    assign issued_u = issued_instr;

    always_comb begin
        if (restore) begin
            pc_nxt = saved_pc;                          // Back to interrupted code
        end else if (issued_u.jmp.op == OP_JUMP) begin
            pc_nxt = {5'b0, issued_u.jmp.target};       // Injected or program jump
        end else if (use_noop || use_int_instr) begin
            pc_nxt = fetch_pc;                          // Frozen during flush and inject
        end else begin
            pc_nxt = fetch_pc + 32'd4;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fetch_pc <= RESET_PC;
        end else begin
            fetch_pc <= pc_nxt;
        end
    end

endmodule

`default_nettype wire

// ==== int_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module int_controller (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [cpu_int_pkg::N_IRQ-1:0]   irq,
    input  logic                            int_ack,
    output logic                            int_req,
    output logic [cpu_int_pkg::N_IRQ-1:0]   irq_ack,
    output logic [cpu_int_pkg::instr_w-1:0] inj_instr,
    output logic                            inj_last
);
    import cpu_int_pkg::*;

    logic [N_IRQ-1:0] pending;      // Sticky request bits
    logic [N_IRQ-1:0] pending_nxt;
    logic [N_IRQ-1:0] sel_mask;     // One-hot on lowest pending
    logic [ID_W-1:0]  sel_id;
    logic [ID_W-1:0]  src_id;       // Source being injected
    logic             movi_phase;   // First injected word
    logic             jump_phase;   // Second injected word
    instr_u           inj_word;

    // Fixed priority with index 0 highest
    always_comb begin
        sel_id   = '0;
        sel_mask = '0;
        for (int i = N_IRQ - 1; i >= 0; i--) begin
            if (pending[i]) begin
                sel_id      = i[ID_W-1:0];
                sel_mask    = '0;
                sel_mask[i] = 1'b1;
            end
        end
    end

    assign irq_ack     = int_ack ? sel_mask : '0;      // Pulse in the ack cycle
    assign pending_nxt = (pending & ~irq_ack) | irq;   // Served bit drops while new lines OR in

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending    <= '0;
            int_req    <= 1'b0;
            movi_phase <= 1'b0;
            jump_phase <= 1'b0;
        end else begin
            pending    <= pending_nxt;
            // Quiet from the ack until the jump word has gone out
            int_req    <= (|pending_nxt) & ~(int_ack | movi_phase);
            movi_phase <= int_ack;
            jump_phase <= movi_phase;
        end
    end

    always_ff @(posedge clk) begin
        if (int_ack) begin
            src_id <= sel_id;   // Id for the injected pair
        end
    end

    // MOVI r13,id then JUMP vector
    always_comb begin
        inj_word = INSTR_NOOP;
        if (movi_phase) begin
            inj_word.imm.op    = OP_MOVI;
            inj_word.imm.rd    = ID_REG;
            inj_word.imm.value = 23'(src_id);
        end else if (jump_phase) begin
            inj_word.jmp.op     = OP_JUMP;
            inj_word.jmp.target = 27'(VECTOR_BASE + (32'(src_id) << 4));
        end
    end

    assign inj_instr = inj_word;
    assign inj_last  = jump_phase;   // Jump closes the injection

    a_ack_pending: assert property (@(posedge clk) disable iff (!rst_n)
        (irq_ack & ~pending) == '0)
        else $error("irq_ack on a source that is not pending");

endmodule

`default_nettype wire

// ==== int_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module int_fsm (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            int_req,
    input  logic [cpu_int_pkg::instr_w-1:0] issued_instr,
    input  logic                            inj_last,
    output logic                            int_ack,
    output logic                            use_int_instr,
    output logic                            use_noop,
    ctx_if.fsm                              ctx
);
    import cpu_int_pkg::*;

    int_state_e state;
    int_state_e next_state;
    logic [2:0] flush_cnt;    // Counts no-op cycles inside a flush
    logic       flush_done;
    logic       in_flush;
    logic       is_reti;
    instr_u     issued_u;

    assign issued_u = issued_instr;
    assign is_reti  = (issued_u.jmp.op == OP_RETI);   // Opcode field shared by both views

    assign in_flush   = (state == FLUSH_INT) || (state == FLUSH_RET);
    assign flush_done = (flush_cnt == FLUSH_DEPTH - 3'd1);

    // Moore outputs and next state logic
    always_comb begin
        next_state    = state;
        use_noop      = 1'b0;
        use_int_instr = 1'b0;
        int_ack       = 1'b0;
        ctx.save      = 1'b0;
        ctx.restore   = 1'b0;

        case (state)
            NORMAL: begin
                if (int_req) begin
                    next_state = FLUSH_INT;     // Request beats a RETI
                end else if (is_reti) begin
                    next_state = FLUSH_RET;
                end
            end

            FLUSH_INT: begin
                use_noop = 1'b1;
                if (flush_done) begin
                    next_state = SAVE_REGS;
                end
            end

            SAVE_REGS: begin
                use_noop   = 1'b1;
                ctx.save   = 1'b1;             // Fetch PC is frozen here
                next_state = ACK_INT;
            end

            ACK_INT: begin
                use_noop   = 1'b1;
                int_ack    = 1'b1;
                next_state = INJECT;
            end

            INJECT: begin
                use_int_instr = 1'b1;          // Controller owns the slot
                if (inj_last) begin
                    next_state = NORMAL;
                end
            end

            FLUSH_RET: begin
                use_noop = 1'b1;
                if (flush_done) begin
                    next_state = RESTORE_REGS;
                end
            end

            RESTORE_REGS: begin
                use_noop    = 1'b1;
                ctx.restore = 1'b1;
                next_state  = NORMAL;
            end

            default: next_state = NORMAL;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= NORMAL;
        end else begin
            state <= next_state;
        end
    end

    // Zero outside a flush and back to zero after the last flush cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            flush_cnt <= '0;
        end else if (in_flush && !flush_done) begin
            flush_cnt <= flush_cnt + 3'd1;
        end else begin
            flush_cnt <= '0;
        end
    end

    a_sel_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(use_noop && use_int_instr))
        else $error("no-op and injection selected together");

    a_ctx_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(ctx.save && ctx.restore))
        else $error("save and restore in the same cycle");

    a_ack_inject: assert property (@(posedge clk) disable iff (!rst_n)
        int_ack |=> (state == INJECT))
        else $error("acknowledge not followed by injection");

    // Controller must close the injection on its second word
    a_inj_len: assert property (@(posedge clk) disable iff (!rst_n)
        (state == INJECT && !inj_last) |=> inj_last)
        else $error("injection ran past the jump word");

endmodule

`default_nettype wire

// ==== list.f ====
cpu_int_pkg.sv
ctx_if.sv
int_controller.sv
int_fsm.sv
ctx_store.sv
fetch_select.sv
cpu_int_top.sv
tb_cpu_int.sv

// ==== tb_cpu_int.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_int;
    import cpu_int_pkg::*;

    logic               clk;
    logic               rst_n;
    logic [N_IRQ-1:0]   irq;
    logic [instr_w-1:0] mem_instr;
    logic [31:0]        cur_lr;
    logic [1:0]         cur_fl;
    logic [31:0]        fetch_pc;
    logic [instr_w-1:0] issued_instr;
    logic [N_IRQ-1:0]   irq_ack;
    logic               restore_valid;
    logic [31:0]        restore_lr;
    logic [1:0]         restore_fl;

    integer seed;
    int     errors;
    int     tests_run;
    int     start_errs;
    int     wait_limit;          // Cycles per wait before giving up
    logic   quiet;               // No request in flight so fetch comes straight from memory

    // Reference model updated on the rising edge
    logic [N_IRQ-1:0] model_pend;
    int               noop_run;  // Consecutive INSTR_NOOP issues before this cycle
    logic [31:0]      prev_pc;
    logic [31:0]      lr_d;
    logic [1:0]       fl_d;
    logic [31:0]      model_lr;  // Copy taken in the save cycle
    logic [1:0]       model_fl;
    logic [31:0]      entry_pc;  // PC frozen at the last entry
    int               last_id;

    cpu_int_top DUT (
        .clk           (clk),
        .rst_n         (rst_n),
        .irq           (irq),
        .mem_instr     (mem_instr),
        .cur_lr        (cur_lr),
        .cur_fl        (cur_fl),
        .fetch_pc      (fetch_pc),
        .issued_instr  (issued_instr),
        .irq_ack       (irq_ack),
        .restore_valid (restore_valid),
        .restore_lr    (restore_lr),
        .restore_fl    (restore_fl)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;   // 40 ns period
    end

    // Program image with a RETI at each vector and address-tagged plain words elsewhere
    function automatic logic [31:0] prog_word(input logic [31:0] pc);
        if (pc >= VECTOR_BASE && pc < VECTOR_BASE + N_IRQ * 16 && pc[3:0] == 4'h0) begin
            return {OP_RETI, 27'h0};
        end
        return {INSTR_NOOP[31:27], pc[26:0]};
    endfunction

    function automatic logic is_plain(input logic [31:0] w);
        return (w[31:27] == INSTR_NOOP[31:27]) && (w != INSTR_NOOP);
    endfunction

    function automatic logic [31:0] vector_of(input int id);
        return VECTOR_BASE + 32'(id) * 32'd16;
    endfunction

    function automatic logic [31:0] movi_word(input int id);
        return {OP_MOVI, ID_REG, 23'(id)};
    endfunction

    function automatic logic [31:0] jump_word(input int id);
        return {OP_JUMP, 27'(vector_of(id))};
    endfunction

    function automatic logic [N_IRQ-1:0] lowest_bit(input logic [N_IRQ-1:0] v);
        return v & (~v + 1'b1);                    // Isolate lowest set bit
    endfunction

    function automatic int id_of(input logic [N_IRQ-1:0] v);
        int id;
        id = 0;
        for (int i = N_IRQ - 1; i >= 0; i--) begin
            if (v[i]) id = i;
        end
        return id;
    endfunction

    // Memory and live context both change on the falling edge
    always @(negedge clk) begin
        mem_instr = prog_word(fetch_pc);
        cur_lr    = $random(seed);
        cur_fl    = 2'($random(seed));
    end

    always @(posedge clk) begin
        prev_pc <= fetch_pc;
        lr_d    <= cur_lr;
        fl_d    <= cur_fl;
        if (!rst_n) begin
            model_pend <= '0;
            noop_run   <= 0;
        end else begin
            model_pend <= model_pend | irq;
            noop_run   <= (issued_instr == INSTR_NOOP) ? noop_run + 1 : 0;
            if (irq_ack != '0) begin
                // Lowest pending source is the one served
                model_pend <= (model_pend & ~lowest_bit(model_pend)) | irq;
                last_id    <= id_of(model_pend);
                entry_pc   <= fetch_pc;            // Still frozen in the ack cycle
                model_lr   <= lr_d;                // Value seen in the save cycle
                model_fl   <= fl_d;
            end
        end
    end

    task automatic mismatch(input string sig, input logic [31:0] exp, input logic [31:0] act);
        $display("FAIL t=%0t %s expected %h got %h", $time, sig, exp, act);
        errors++;
    endtask

    a_reset_pc: assert property (@(posedge clk) $rose(rst_n) |-> fetch_pc == RESET_PC)
        else mismatch("fetch_pc", RESET_PC, $sampled(fetch_pc));
    a_reset_quiet: assert property (@(posedge clk)
        $rose(rst_n) |-> !restore_valid && irq_ack == '0)
        else begin
            $display("ERROR t=%0t restore_valid or irq_ack active right after reset", $time);
            errors++;
        end
    a_issue_mem: assert property (@(posedge clk) disable iff (!rst_n)
        quiet |-> issued_instr == mem_instr)
        else mismatch("issued_instr", $sampled(mem_instr), $sampled(issued_instr));
    a_pc_step: assert property (@(posedge clk) disable iff (!rst_n)
        is_plain(issued_instr) |=> fetch_pc == prev_pc + 32'd4)
        else mismatch("fetch_pc", $sampled(prev_pc) + 32'd4, $sampled(fetch_pc));
    a_pc_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (issued_instr == INSTR_NOOP && !restore_valid) || issued_instr[31:27] == OP_MOVI
        |=> fetch_pc == prev_pc)
        else mismatch("fetch_pc", $sampled(prev_pc), $sampled(fetch_pc));

    // Entry gives 8 no-ops with the ack in the last one, then MOVI and JUMP
    a_ack_flush: assert property (@(posedge clk) disable iff (!rst_n)
        irq_ack != '0 |-> noop_run == 7 && issued_instr == INSTR_NOOP)
        else mismatch("no-op run at irq_ack", 8, $sampled(noop_run) + 1);
    a_ack_src: assert property (@(posedge clk) disable iff (!rst_n)
        irq_ack != '0 |-> irq_ack == lowest_bit(model_pend))
        else mismatch("irq_ack", lowest_bit($sampled(model_pend)), $sampled(irq_ack));
    a_movi: assert property (@(posedge clk) disable iff (!rst_n)
        irq_ack != '0 |=> issued_instr == movi_word(last_id))
        else mismatch("issued_instr", movi_word($sampled(last_id)), $sampled(issued_instr));
    a_jump: assert property (@(posedge clk) disable iff (!rst_n)
        irq_ack != '0 |-> ##2 issued_instr == jump_word(last_id))
        else mismatch("issued_instr", jump_word($sampled(last_id)), $sampled(issued_instr));
    a_target: assert property (@(posedge clk) disable iff (!rst_n)
        irq_ack != '0 |-> ##3 fetch_pc == vector_of(last_id))
        else mismatch("fetch_pc", vector_of($sampled(last_id)), $sampled(fetch_pc));

    // Return path
    a_ret_flush: assert property (@(posedge clk) disable iff (!rst_n)
        restore_valid |-> noop_run == 6 && issued_instr == INSTR_NOOP)
        else mismatch("no-op run before restore", 6, $sampled(noop_run));
    a_ret_lr: assert property (@(posedge clk) disable iff (!rst_n)
        restore_valid |-> restore_lr == model_lr)
        else mismatch("restore_lr", $sampled(model_lr), $sampled(restore_lr));
    a_ret_fl: assert property (@(posedge clk) disable iff (!rst_n)
        restore_valid |-> restore_fl == model_fl)
        else mismatch("restore_fl", 32'($sampled(model_fl)), 32'($sampled(restore_fl)));
    a_ret_pc: assert property (@(posedge clk) disable iff (!rst_n)
        restore_valid |=> fetch_pc == entry_pc)
        else mismatch("fetch_pc", $sampled(entry_pc), $sampled(fetch_pc));
    a_reti_return: assert property (@(posedge clk) disable iff (!rst_n)
        issued_instr[31:27] == OP_RETI && model_pend == '0 |-> ##7 restore_valid)
        else mismatch("restore_valid", 1, $sampled(restore_valid));
    // Pending request wins over a RETI in the same cycle
    a_reti_req: assert property (@(posedge clk) disable iff (!rst_n)
        issued_instr[31:27] == OP_RETI && model_pend != '0 |-> ##8 irq_ack != '0)
        else mismatch("irq_ack", lowest_bit($sampled(model_pend)), $sampled(irq_ack));

    task automatic apply_reset();
        rst_n = 1'b0;
        irq   = '0;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
    endtask

    task automatic pulse_irq(input logic [N_IRQ-1:0] mask);
        irq = mask;                                // High at exactly one rising edge
        @(negedge clk);
        irq = '0;
    endtask

    function automatic logic seen(input string what);
        if (what == "irq_ack") return irq_ack != '0;
        if (what == "jump") return issued_instr[31:27] == OP_JUMP;
        return restore_valid;
    endfunction

    task automatic wait_until(input string what);
        int cnt;
        cnt = 0;
        @(negedge clk);
        while (!seen(what) && cnt < wait_limit) begin
            @(negedge clk);
            cnt++;
        end
        if (!seen(what)) begin
            $display("ERROR t=%0t timed out after %0d cycles waiting for %s",
                     $time, wait_limit, what);
            errors++;
        end
    endtask

    task automatic test_done(input string name);
        tests_run++;
        $display("test %0d %s finished with %0d errors", tests_run, name,
                 errors - start_errs);
        start_errs = errors;
    endtask

    initial begin
        seed       = 14;
        errors     = 0;
        tests_run  = 0;
        start_errs = 0;
        wait_limit = 40;
        quiet      = 1'b0;
        irq        = '0;
        cur_lr     = '0;
        cur_fl     = '0;
        rst_n      = 1'b0;
        mem_instr  = prog_word(RESET_PC);

        apply_reset();
        quiet = 1'b1;
        repeat (12) @(negedge clk);
        quiet = 1'b0;
        test_done("reset and plain fetch");

        pulse_irq(8'h08);                          // Source 3 from main code
        wait_until("irq_ack");
        wait_until("jump");
        repeat (2) @(negedge clk);
        test_done("interrupt entry");

        wait_until("restore_valid");               // Vector 3 holds a RETI
        repeat (2) @(negedge clk);
        test_done("return from interrupt");

        apply_reset();
        pulse_irq(8'h24);                          // Sources 5 and 2 together
        wait_until("irq_ack");
        wait_until("irq_ack");
        wait_until("restore_valid");
        repeat (2) @(negedge clk);
        test_done("fixed priority");

        apply_reset();
        pulse_irq(8'h02);
        wait_until("jump");
        irq = 8'h40;                               // Pending by the RETI cycle
        @(negedge clk);
        irq = '0;
        wait_until("irq_ack");
        wait_until("restore_valid");
        repeat (2) @(negedge clk);
        test_done("request over return");

        $display("%0d tests run, %0d errors", tests_run, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire
